/* streamSubsystem.f */
design/streamPkg.sv
design/streamCtrl.sv
design/intCountSource.sv
design/intAccumulator.sv
design/laneSum.sv
design/blobScrambler.sv
design/streamSubsystem.sv
tests/streamChecker.sv
tests/streamSubsystemTb.sv

/* tests/streamSubsystemTb.sv */
// drives the stream subsystem through counter, lane, scramble and mode-change traffic
// inputs change on the falling edge and random stimulus comes from $urandom

`timescale 1ns/1ps

module streamSubsystemTb;

  localparam logic [31:0] CountStart = 32'hFFFF_FFFC;
  localparam logic [31:0] PadSeed    = 32'hC3A5_0F96;
  localparam int AccBeats    = 40;
  localparam int LaneBeats   = 24;
  localparam int ScrBeats    = 24;
  localparam int AccExtBeats = 16;
  localparam int ScrTail     = 8;
  localparam int TotalBeats  = AccBeats + LaneBeats + ScrBeats + AccExtBeats + ScrTail;
  localparam int ClkPeriod   = 100;
  localparam int TimeoutNs   = (TotalBeats * 4 + 200) * ClkPeriod;

  logic clk;
  logic rstn;
  logic srcSel;
  logic modeLoad;
  streamPkg::streamMode_e newMode;
  logic modeBusy;
  logic inValid;
  logic [31:0] inData;
  logic inReady;
  logic outValid;
  logic [31:0] outData;
  logic outReady;
  logic bpOn = 1'b0;
  int tbErrors = 0;
  int unsigned seedInit;

  // lane corner cases starting with -128 + -128
  logic [31:0] edgeWords [5] = '{32'h8080_8080, 32'h7F7F_7F7F, 32'h80FF_7F01,
                                 32'hFFFF_FFFF, 32'h0000_0000};

  streamSubsystem #(.CountStart(CountStart), .PadSeed(PadSeed)) u_streamSubsystem (
    .clk(clk), .rstn(rstn), .srcSel(srcSel), .modeLoad(modeLoad), .newMode(newMode),
    .modeBusy(modeBusy), .inValid(inValid), .inData(inData), .inReady(inReady),
    .outValid(outValid), .outData(outData), .outReady(outReady)
  );

  streamChecker #(.CountStart(CountStart), .PadSeed(PadSeed)) u_checker (
    .clk(clk), .rstn(rstn), .modeLoad(modeLoad), .newMode(newMode), .modeBusy(modeBusy),
    .inValid(inValid), .inData(inData), .inReady(inReady),
    .outValid(outValid), .outData(outData), .outReady(outReady)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // outReady low about a quarter of the time once traffic starts
  always @(negedge clk) begin
    outReady = bpOn ? ($urandom_range(3) != 0) : 1'b1;
  end

  task automatic checkIdle(input string label);
    assert (!outValid && !inReady && !modeBusy) else begin
      $display("%s: outValid, inReady or modeBusy high around reset", label);
      tbErrors++;
    end
  endtask

  task automatic sendWord(input logic [31:0] d);
    repeat ($urandom_range(2)) @(negedge clk);
    inValid = 1'b1;
    inData  = d;
    @(posedge clk);
    while (!inReady) @(posedge clk);
    @(negedge clk);
    inValid = 1'b0;
  endtask

  task automatic sendWords(input int n, input bit withEdges);
    for (int i = 0; i < n; i++) begin
      sendWord((withEdges && i < 5) ? edgeWords[i] : $urandom);
    end
  endtask

  task automatic requestMode(input streamPkg::streamMode_e m);
    @(negedge clk);
    modeLoad = 1'b1;
    newMode  = m;
  endtask

  task automatic finishModeRequest;
    @(negedge clk);
    modeLoad = 1'b0;
    assert (modeBusy) else begin
      $display("%s: modeBusy did not rise after modeLoad", u_checker.testName);
      tbErrors++;
    end
    while (modeBusy) @(negedge clk);
  endtask

  task automatic drain;
    @(negedge clk);
    while (outValid) @(negedge clk);
  endtask

  initial begin
    seedInit = $urandom(92);
    rstn = 1'b0;
    // external source selected during reset so inReady depends on the reset state
    srcSel = 1'b0;
    modeLoad = 1'b0;
    newMode = streamPkg::ModeAcc;
    inValid = 1'b0;
    inData = '0;
    outReady = 1'b0;
    repeat (4) begin
      @(negedge clk);
      checkIdle("reset");
    end
    rstn = 1'b1;
    srcSel = 1'b1;
    @(negedge clk);
    checkIdle("afterReset");
    bpOn = 1'b1;

    u_checker.testName = "accCounter";
    while (u_checker.outCount < AccBeats) @(negedge clk);
    srcSel = 1'b0;
    drain();

    u_checker.testName = "laneExt";
    requestMode(streamPkg::ModeLane);
    finishModeRequest();
    sendWords(LaneBeats, 1'b1);

    // switch to scramble while lane words are still flowing
    u_checker.testName = "laneToScramble";
    fork
      sendWords(ScrBeats, 1'b0);
      begin
        repeat (5) @(negedge clk);
        requestMode(streamPkg::ModeScramble);
        finishModeRequest();
      end
    join
    drain();

    // the second request replaces the first
    // code 3 behaves as accumulate
    u_checker.testName = "accExtCarry";
    requestMode(streamPkg::ModeLane);
    requestMode(streamPkg::streamMode_e'(2'd3));
    finishModeRequest();
    sendWords(AccExtBeats, 1'b0);

    u_checker.testName = "scrambleCarry";
    requestMode(streamPkg::ModeScramble);
    finishModeRequest();
    sendWords(ScrTail, 1'b0);
    drain();
    bpOn = 1'b0;

    assert (u_checker.inCount == u_checker.extOutCount) else begin
      $display("external words lost or duplicated: %0d in, %0d out",
               u_checker.inCount, u_checker.extOutCount);
      tbErrors++;
    end

    $display("Errors: checker %0d, testbench %0d", u_checker.errCount, tbErrors);
    if (u_checker.errCount == 0 && tbErrors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(TimeoutNs);
    $display("run timed out after %0d ns", TimeoutNs);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* tests/streamChecker.sv */
// reference model and checks for the stream subsystem sampled on rising clk
// counter words are not visible at the ports and come from a local counter model

`timescale 1ns/1ps

module streamChecker #(
  parameter logic [31:0] CountStart = '0,
  parameter logic [31:0] PadSeed    = 32'h5a3c_96e1
) (
  input logic                          clk,
  input logic                          rstn,
  input logic                          modeLoad,
  input streamPkg::streamMode_e        newMode,
  input logic                          modeBusy,
  input logic                          inValid,
  input logic [streamPkg::DataWidth-1:0] inData,
  input logic                          inReady,
  input logic                          outValid,
  input logic [streamPkg::DataWidth-1:0] outData,
  input logic                          outReady
);

  string testName = "reset";
  int errCount = 0;
  int inCount = 0;
  int extOutCount = 0;
  int outCount = 0;

  logic [31:0] extQ[$];
  logic [31:0] cntModel;
  logic [31:0] totalModel;
  logic [31:0] padModel;
  logic [31:0] word;
  logic [31:0] expected;
  logic busyModel;
  streamPkg::streamMode_e modeModel;
  streamPkg::streamMode_e pendModel;

  function automatic logic [31:0] predictResult(input logic [31:0] data);
    streamPkg::laneWord_u view;
    logic [15:0] sumLow;
    logic [15:0] sumHigh;
    logic [31:0] result;
    view.raw = data;
    case (modeModel)
      streamPkg::ModeLane: begin
        sumLow  = {{8{view.lanes[0][7]}}, view.lanes[0]}
                + {{8{view.lanes[1][7]}}, view.lanes[1]};
        sumHigh = {{8{view.lanes[2][7]}}, view.lanes[2]}
                + {{8{view.lanes[3][7]}}, view.lanes[3]};
        result  = {sumHigh, sumLow};
      end
      streamPkg::ModeScramble: begin
        result   = data ^ padModel;
        padModel = {padModel[7:0], padModel[31:8]};
      end
      default: begin
        totalModel = totalModel + data;
        result     = totalModel;
      end
    endcase
    return result;
  endfunction

  always @(posedge clk) begin
    if (!rstn) begin
      extQ.delete();
      cntModel   = CountStart;
      totalModel = '0;
      padModel   = PadSeed;
      busyModel  = 1'b0;
      modeModel  = streamPkg::ModeAcc;
      pendModel  = streamPkg::ModeAcc;
    end else begin
      assert (modeBusy == busyModel) else begin
        $display("Fail %s modeBusy expected %0b actual %0b", testName, busyModel, modeBusy);
        errCount++;
      end
      assert (!(inValid && inReady && modeBusy)) else begin
        $display("%s: input accepted while a mode change was pending", testName);
        errCount++;
      end
      // outputs leave in acceptance order and an empty queue means a counter word
      if (outValid && outReady) begin
        if (extQ.size() > 0) begin
          word = extQ.pop_front();
          extOutCount++;
        end else begin
          word = cntModel;
          cntModel = cntModel + 1;
        end
        expected = predictResult(word);
        outCount++;
        assert (outData == expected) else begin
          $display("Fail %s expected %h actual %h", testName, expected, outData);
          errCount++;
        end
      end
      if (inValid && inReady) begin
        extQ.push_back(inData);
        inCount++;
      end
      if (modeLoad) begin
        busyModel = 1'b1;
        if (newMode == streamPkg::ModeLane || newMode == streamPkg::ModeScramble) begin
          pendModel = newMode;
        end else begin
          pendModel = streamPkg::ModeAcc;
        end
      end else if (busyModel && !outValid) begin
        modeModel = pendModel;
        busyModel = 1'b0;
      end
    end
  end

  // a stalled word must stay put until it is taken
  assert property (@(posedge clk) disable iff (!rstn)
    (outValid && !outReady) |=> (outValid && $stable(outData)))
  else begin
    $display("%s: output word dropped or changed while outReady was low", testName);
    errCount++;
  end

  // every accepted external word shows up as a result on the next cycle
  assert property (@(posedge clk) disable iff (!rstn)
    (inValid && inReady) |=> outValid)
  else begin
    $display("%s: no result one cycle after an input was accepted", testName);
    errCount++;
  end

endmodule

/* design/streamSubsystem.sv */
// top level: counter or external source, three datapaths, one output stream
// input acceptance to outValid is one cycle

`timescale 1ns/1ps

module streamSubsystem #(
  parameter logic [streamPkg::DataWidth-1:0] CountStart = '0,
  parameter logic [streamPkg::DataWidth-1:0] PadSeed    = 32'h5a3c_96e1
) (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              srcSel,
  input  logic                              modeLoad,
  input  streamPkg::streamMode_e            newMode,
  output logic                              modeBusy,
  input  logic                              inValid,
  input  logic [streamPkg::DataWidth-1:0]   inData,
  output logic                              inReady,
  output logic                              outValid,
  output logic [streamPkg::DataWidth-1:0]   outData,
  input  logic                              outReady
);

  logic cntValid;
  logic cntReady;
  logic [streamPkg::DataWidth-1:0] cntData;
  logic [streamPkg::DataWidth-1:0] srcData;

  logic accValid;
  logic accReady;
  logic accOutValid;
  logic accOutReady;
  logic [streamPkg::DataWidth-1:0] accOutData;

  logic laneValid;
  logic laneReady;
  logic laneOutValid;
  logic laneOutReady;
  logic [streamPkg::DataWidth-1:0] laneOutData;

  logic scrValid;
  logic scrReady;
  logic scrOutValid;
  logic scrOutReady;
  logic [streamPkg::DataWidth-1:0] scrOutData;

  streamCtrl u_streamCtrl (
    .clk          (clk),
    .rstn         (rstn),
    .srcSel       (srcSel),
    .modeLoad     (modeLoad),
    .newMode      (newMode),
    .modeBusy     (modeBusy),
    .inValid      (inValid),
    .inData       (inData),
    .inReady      (inReady),
    .cntValid     (cntValid),
    .cntData      (cntData),
    .cntReady     (cntReady),
    .srcData      (srcData),
    .accValid     (accValid),
    .laneValid    (laneValid),
    .scrValid     (scrValid),
    .accReady     (accReady),
    .laneReady    (laneReady),
    .scrReady     (scrReady),
    .accOutValid  (accOutValid),
    .accOutData   (accOutData),
    .laneOutValid (laneOutValid),
    .laneOutData  (laneOutData),
    .scrOutValid  (scrOutValid),
    .scrOutData   (scrOutData),
    .accOutReady  (accOutReady),
    .laneOutReady (laneOutReady),
    .scrOutReady  (scrOutReady),
    .outValid     (outValid),
    .outData      (outData),
    .outReady     (outReady)
  );

  intCountSource #(.CountStart(CountStart)) u_intCountSource (
    .clk      (clk),
    .rstn     (rstn),
    .cntValid (cntValid),
    .cntData  (cntData),
    .cntReady (cntReady)
  );

  intAccumulator u_intAccumulator (
    .clk         (clk),
    .rstn        (rstn),
    .accValid    (accValid),
    .srcData     (srcData),
    .accReady    (accReady),
    .accOutValid (accOutValid),
    .accOutData  (accOutData),
    .accOutReady (accOutReady)
  );

  laneSum u_laneSum (
    .clk          (clk),
    .rstn         (rstn),
    .laneValid    (laneValid),
    .srcData      (srcData),
    .laneReady    (laneReady),
    .laneOutValid (laneOutValid),
    .laneOutData  (laneOutData),
    .laneOutReady (laneOutReady)
  );

  blobScrambler #(.PadSeed(PadSeed)) u_blobScrambler (
    .clk         (clk),
    .rstn        (rstn),
    .scrValid    (scrValid),
    .srcData     (srcData),
    .scrReady    (scrReady),
    .scrOutValid (scrOutValid),
    .scrOutData  (scrOutData),
    .scrOutReady (scrOutReady)
  );

endmodule

/* design/blobScrambler.sv */
// XOR scrambler, the pad rotates right by one lane on each accepted word
// pad state survives mode changes and returns to PadSeed only on reset

`timescale 1ns/1ps

module blobScrambler #(
  parameter logic [streamPkg::DataWidth-1:0] PadSeed = 32'h5a3c_96e1
) (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              scrValid,
  input  logic [streamPkg::DataWidth-1:0]   srcData,
  output logic                              scrReady,
  output logic                              scrOutValid,
  output logic [streamPkg::DataWidth-1:0]   scrOutData,
  input  logic                              scrOutReady
);

  localparam int Shift = streamPkg::LaneWidth;

  logic [streamPkg::DataWidth-1:0] pad;
  logic [streamPkg::DataWidth-1:0] padNext;
  logic accept;

  // rotate right by one byte
  assign padNext = {pad[Shift-1:0], pad[streamPkg::DataWidth-1:Shift]};

  assign scrReady = !scrOutValid || scrOutReady;
  assign accept   = scrValid && scrReady;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pad         <= PadSeed;
      scrOutValid <= 1'b0;
    end else begin
      if (accept) begin
        pad         <= padNext;
        scrOutValid <= 1'b1;
      end else if (scrOutReady) begin
        scrOutValid <= 1'b0;
      end
    end
  end

  // the current pad is used, the rotated one serves the next word
  always_ff @(posedge clk) begin
    if (accept) begin
      scrOutData <= srcData ^ pad;
    end
  end

endmodule

/* design/laneSum.sv */
// signed pairwise lane adder, one registered result per accepted word
// low half holds lane0+lane1, high half holds lane2+lane3, both sign-extended

`timescale 1ns/1ps

module laneSum (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              laneValid,
  input  logic [streamPkg::DataWidth-1:0]   srcData,
  output logic                              laneReady,
  output logic                              laneOutValid,
  output logic [streamPkg::DataWidth-1:0]   laneOutData,
  input  logic                              laneOutReady
);

  streamPkg::laneWord_u word;
  logic signed [streamPkg::SumWidth-1:0] sumLow;
  logic signed [streamPkg::SumWidth-1:0] sumHigh;
  logic accept;

  assign word.raw = srcData;

  // widen each lane before adding so -128 + -128 stays exact
  assign sumLow  = streamPkg::SumWidth'($signed(word.lanes[0]))
                 + streamPkg::SumWidth'($signed(word.lanes[1]));
  assign sumHigh = streamPkg::SumWidth'($signed(word.lanes[2]))
                 + streamPkg::SumWidth'($signed(word.lanes[3]));

  assign laneReady = !laneOutValid || laneOutReady;
  assign accept    = laneValid && laneReady;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      laneOutValid <= 1'b0;
    end else begin
      if (accept) begin
        laneOutValid <= 1'b1;
      end else if (laneOutReady) begin
        laneOutValid <= 1'b0;
      end
    end
  end

  // payload only changes on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      laneOutData <= {sumHigh, sumLow};
    end
  end

endmodule

/* design/intAccumulator.sv */
// running total stage, one registered result per accepted word
// the total wraps modulo 2^32 and clears only on reset

`timescale 1ns/1ps

module intAccumulator (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              accValid,
  input  logic [streamPkg::DataWidth-1:0]   srcData,
  output logic                              accReady,
  output logic                              accOutValid,
  output logic [streamPkg::DataWidth-1:0]   accOutData,
  input  logic                              accOutReady
);

  logic [streamPkg::DataWidth-1:0] total;
  logic accept;

  // ready when empty or when the held result leaves this cycle
  assign accReady = !accOutValid || accOutReady;
  assign accept   = accValid && accReady;

  // the result register is the total itself, held until it is taken
  assign accOutData = total;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      total       <= '0;
      accOutValid <= 1'b0;
    end else begin
      if (accept) begin
        total       <= total + srcData;
        accOutValid <= 1'b1;
      end else if (accOutReady) begin
        accOutValid <= 1'b0;
      end
    end
  end

endmodule

/* design/intCountSource.sv */
// incrementing integer producer, wraps at 32 bits
// valid rises on the first edge after reset and then stays high

`timescale 1ns/1ps

module intCountSource #(
  parameter logic [streamPkg::DataWidth-1:0] CountStart = '0
) (
  input  logic                              clk,
  input  logic                              rstn,
  output logic                              cntValid,
  output logic [streamPkg::DataWidth-1:0]   cntData,
  input  logic                              cntReady
);

  logic [streamPkg::DataWidth-1:0] count;

  assign cntData = count;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      count    <= CountStart;
      cntValid <= 1'b0;
    end else begin
      cntValid <= 1'b1;
      // advance only when the current value has been taken
      if (cntValid && cntReady) begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

/* design/streamCtrl.sv */
// mode register, source select, routing to one datapath and output merge
// a mode change stalls both sources until every stage has drained
// the fourth mode code is stored as accumulate

`timescale 1ns/1ps

module streamCtrl (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              srcSel,
  input  logic                              modeLoad,
  input  streamPkg::streamMode_e            newMode,
  output logic                              modeBusy,
  input  logic                              inValid,
  input  logic [streamPkg::DataWidth-1:0]   inData,
  output logic                              inReady,
  input  logic                              cntValid,
  input  logic [streamPkg::DataWidth-1:0]   cntData,
  output logic                              cntReady,
  output logic [streamPkg::DataWidth-1:0]   srcData,
  output logic                              accValid,
  output logic                              laneValid,
  output logic                              scrValid,
  input  logic                              accReady,
  input  logic                              laneReady,
  input  logic                              scrReady,
  input  logic                              accOutValid,
  input  logic [streamPkg::DataWidth-1:0]   accOutData,
  input  logic                              laneOutValid,
  input  logic [streamPkg::DataWidth-1:0]   laneOutData,
  input  logic                              scrOutValid,
  input  logic [streamPkg::DataWidth-1:0]   scrOutData,
  output logic                              accOutReady,
  output logic                              laneOutReady,
  output logic                              scrOutReady,
  output logic                              outValid,
  output logic [streamPkg::DataWidth-1:0]   outData,
  input  logic                              outReady
);

  streamPkg::streamMode_e mode;
  streamPkg::streamMode_e pendMode;
  streamPkg::streamMode_e loadMode;
  logic live;
  logic drained;
  logic gate;
  logic srcValid;
  logic stageReady;

  // fold the unused code onto accumulate before it is stored
  always_comb begin
    case (newMode)
      streamPkg::ModeLane, streamPkg::ModeScramble: loadMode = newMode;
      default: loadMode = streamPkg::ModeAcc;
    endcase
  end

  assign drained = !(accOutValid || laneOutValid || scrOutValid);

  // modeBusy doubles as the pending flag
  always_ff @(posedge clk) begin
    if (!rstn) begin
      mode     <= streamPkg::ModeAcc;
      pendMode <= streamPkg::ModeAcc;
      modeBusy <= 1'b0;
      live     <= 1'b0;
    end else begin
      live <= 1'b1;
      if (modeLoad) begin
        // a later request replaces one still waiting
        pendMode <= loadMode;
        modeBusy <= 1'b1;
      end else if (modeBusy && drained) begin
        mode     <= pendMode;
        modeBusy <= 1'b0;
      end
    end
  end

  // sources stay stalled in the first cycle after reset and during a change
  assign gate     = live && !modeBusy;
  assign srcValid = srcSel ? cntValid : inValid;
  assign srcData  = srcSel ? cntData : inData;

  always_comb begin
    accValid   = 1'b0;
    laneValid  = 1'b0;
    scrValid   = 1'b0;
    stageReady = accReady;
    case (mode)
      streamPkg::ModeLane: begin
        laneValid  = srcValid && gate;
        stageReady = laneReady;
      end
      streamPkg::ModeScramble: begin
        scrValid   = srcValid && gate;
        stageReady = scrReady;
      end
      default: begin
        accValid   = srcValid && gate;
        stageReady = accReady;
      end
    endcase
  end

  // the unselected source always sees ready low
  assign cntReady = srcSel && gate && stageReady;
  assign inReady  = !srcSel && gate && stageReady;

  // at most one stage holds data, the fixed priority only matters for safety
  assign outValid = accOutValid || laneOutValid || scrOutValid;

  always_comb begin
    if (accOutValid) begin
      outData = accOutData;
    end else if (laneOutValid) begin
      outData = laneOutData;
    end else begin
      outData = scrOutData;
    end
  end

  assign accOutReady  = outReady;
  assign laneOutReady = outReady && !accOutValid;
  assign scrOutReady  = outReady && !accOutValid && !laneOutValid;

endmodule

/* design/streamPkg.sv */
// shared widths, the datapath mode and the lane view of a stream word
// every stream word is 32 bits, seen as four signed 8-bit lanes where needed

package streamPkg;

  // width of every stream word
  parameter int DataWidth = 32;

  // lane layout of one word, lane 0 sits in the low byte
  parameter int LaneCount = 4;
  parameter int LaneWidth = 8;

  // each lane-pair sum is widened to this many bits
  parameter int SumWidth = 16;

  // datapath selected by the control block
  // the unused fourth code behaves as accumulate
  typedef enum logic [1:0] {
    ModeAcc      = 2'd0,
    ModeLane     = 2'd1,
    ModeScramble = 2'd2
  } streamMode_e;

  // one signed lane
  typedef logic signed [LaneWidth-1:0] lane_t;

  // one stream word, read either as a raw integer or as signed lanes
  typedef union packed {
    logic [DataWidth-1:0]    raw;
    lane_t [LaneCount-1:0]   lanes;
  } laneWord_u;

endpackage
